//--- project.f
+incdir+design
design/mem_pkg.sv
design/data_cache.sv
design/bus_arbiter.sv
design/dma_counter.sv
design/dma_engine.sv
design/main_memory.sv
design/mem_subsystem.sv
tb/tb_mem_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f project.f --top-module tb_mem_subsystem \
	-Mdir obj_dir -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "compile or run step failed"

cat sim.log 2>/dev/null
grep -qx "TESTS PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- tb/tb_mem_subsystem.sv
`timescale 1ns/100ps
`include "mem_defines.svh"

module tb_mem_subsystem;
	import mem_pkg::*;

	localparam int CPU_TIMEOUT = 300;
	localparam int DMA_TIMEOUT = 2000;
	// cycles watched after the completion pulse for stray pulses
	localparam int DMA_TAIL    = 10;

	logic                   clk = 1'b0;
	logic                   rst_n;
	cpu_req_t               cpu_req;
	logic [`WORD_SIZE-1:0]  cpu_rdata;
	logic                   cpu_ready;
	logic                   cpu_ack;
	logic                   ex_interrupt;
	logic [`WORD_SIZE-1:0]  dev_data;
	logic                   dev_rd;
	logic                   dma_interrupt;
	logic                   bus_grant;

	logic [`WORD_SIZE-1:0]  model [`MEM_DEPTH];
	logic [`WORD_SIZE-1:0]  dev_words [`DMA_LEN];
	logic [`WORD_SIZE-1:0]  wr_addrs [16];
	integer                 seed;
	int                     data_errs;
	int                     op_errs;
	int                     timeouts;
	int                     dev_count;
	int                     irq_count;

	mem_subsystem mem_subsystem_i (
		.i_clk           (clk),
		.i_rst_n         (rst_n),
		.i_cpu_req       (cpu_req),
		.o_cpu_rdata     (cpu_rdata),
		.o_cpu_ready     (cpu_ready),
		.o_cpu_ack       (cpu_ack),
		.i_ex_interrupt  (ex_interrupt),
		.i_dev_data      (dev_data),
		.o_dev_rd        (dev_rd),
		.o_dma_interrupt (dma_interrupt),
		.o_bus_grant     (bus_grant)
	);

	always #10 clk = ~clk;

	task automatic check_word(input logic [`WORD_SIZE-1:0] got,
			input logic [`WORD_SIZE-1:0] exp, input string what);
		if (got !== exp) begin
			data_errs++;
			$display("[ERROR] time %0t: %s returned %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_mem_op(input mem_op_e got, input mem_op_e exp, input string what);
		if (got !== exp) begin
			op_errs++;
			$display("[ERROR] time %0t: %s was %s, expected %s", $time, what,
				got.name(), exp.name());
		end
	endtask

	// one CPU request held as a level until its ready or ack pulse
	task automatic cpu_access(input mem_op_e op, input logic [`WORD_SIZE-1:0] addr,
			input logic [`WORD_SIZE-1:0] wdata, output logic [`WORD_SIZE-1:0] rdata);
		int       cycles;
		logic     done;
		mem_op_e  resp;
		rdata = '0;
		resp = OP_NONE;
		done = 1'b0;
		cycles = 0;
		if (timeouts == 0) begin
			@(negedge clk);
			cpu_req = '{op: op, addr: addr, wdata: wdata};
			while (!done && cycles < CPU_TIMEOUT) begin
				@(negedge clk);
				cycles++;
				if (cpu_ready || cpu_ack) begin
					done = 1'b1;
					resp = cpu_ready ? OP_READ : OP_WRITE;
					rdata = cpu_rdata;
				end
			end
			cpu_req = '{op: OP_NONE, addr: '0, wdata: '0};
			if (done) begin
				check_mem_op(resp, op, $sformatf("response to request at %h", addr));
			end else begin
				timeouts++;
				$display("timeout: CPU %s at address %h got no answer in %0d cycles",
					op.name(), addr, CPU_TIMEOUT);
			end
		end
	endtask

	task automatic cpu_write(input logic [`WORD_SIZE-1:0] addr,
			input logic [`WORD_SIZE-1:0] wdata);
		logic [`WORD_SIZE-1:0] unused_rdata;
		cpu_access(OP_WRITE, addr, wdata, unused_rdata);
		model[addr[7:0]] = wdata;
	endtask

	task automatic cpu_read_check(input logic [`WORD_SIZE-1:0] addr);
		logic [`WORD_SIZE-1:0] got;
		cpu_access(OP_READ, addr, '0, got);
		if (timeouts == 0) begin
			check_word(got, model[addr[7:0]], $sformatf("read of %h", addr));
		end
	endtask

	// starts the transfer and keeps the CPU busy away from the DMA lines until it ends
	task automatic run_dma_with_traffic();
		int                     cycles;
		int                     tail;
		int                     n;
		logic [`WORD_SIZE-1:0]  addr;
		logic [`WORD_SIZE-1:0]  wdata;
		cycles = 0;
		tail = 0;
		n = 0;
		dev_data = dev_words[0];
		@(negedge clk);
		ex_interrupt = 1'b1;
		fork
			begin
				while (tail < DMA_TAIL && cycles < DMA_TIMEOUT) begin
					@(negedge clk);
					cycles++;
					ex_interrupt = 1'b0;
					// no cache access may be in flight while the DMA owns the port
					if (bus_grant) begin
						check_mem_op(mem_subsystem_i.cache_mem_req.op, OP_NONE,
							"cache port op under grant");
					end
					// the word on the bus now is taken at the next rising edge
					if (dev_rd) begin
						model[8'(`DMA_BASE + dev_count)] = dev_data;
						dev_count++;
					end else if (dev_count < `DMA_LEN) begin
						dev_data = dev_words[dev_count];
					end
					if (dma_interrupt) begin
						irq_count++;
					end
					if (irq_count != 0) begin
						tail++;
					end
				end
			end
			begin
				while (irq_count == 0 && n < 40) begin
					// only sets 1 to 4 so the cached DMA lines stay resident
					addr = 16'h0044 + 16'(4'($random(seed)));
					if ($random(seed) % 2 == 0) begin
						wdata = 16'($random(seed));
						cpu_write(addr, wdata);
					end else begin
						cpu_read_check(addr);
					end
					n++;
				end
			end
		join
		if (tail < DMA_TAIL) begin
			timeouts++;
			$display("timeout: DMA transfer did not finish within %0d cycles", DMA_TIMEOUT);
		end
	endtask

	initial begin : stimulus
		logic [`WORD_SIZE-1:0] base;
		logic [`WORD_SIZE-1:0] wdata;
		logic [1:0]            off;
		seed = 83178;
		data_errs = 0;
		op_errs = 0;
		timeouts = 0;
		dev_count = 0;
		irq_count = 0;
		rst_n = 1'b0;
		cpu_req = '{op: OP_NONE, addr: '0, wdata: '0};
		ex_interrupt = 1'b0;
		dev_data = '0;
		for (int i = 0; i < `MEM_DEPTH; i++) begin
			model[i] = '0;
		end
		for (int i = 0; i < `DMA_LEN; i++) begin
			dev_words[i] = 16'($random(seed));
		end
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		check_mem_op(mem_subsystem_i.cache_mem_req.op, OP_NONE, "cache port op after reset");
		check_mem_op(mem_subsystem_i.dma_mem_req.op, OP_NONE, "DMA port op after reset");
		check_word(16'({cpu_ready, cpu_ack, dev_rd, dma_interrupt, bus_grant}), 16'd0,
			"control outputs after reset");

		for (int i = 0; i < 16; i++) begin
			wr_addrs[i] = {8'h00, 8'($random(seed))};
			wdata = 16'($random(seed));
			cpu_write(wr_addrs[i], wdata);
		end
		for (int i = 0; i < 16; i++) begin
			cpu_read_check(wr_addrs[i]);
		end

		// refill of one line, hits on it, then a store into the hit line
		base = {8'h00, 6'($random(seed)), 2'b00};
		for (int pass = 0; pass < 2; pass++) begin
			for (int j = 0; j < `LINE_WORDS; j++) begin
				cpu_read_check(base + 16'(j));
			end
		end
		off = 2'($random(seed));
		wdata = 16'($random(seed));
		cpu_write(base + 16'(off), wdata);
		for (int j = 0; j < `LINE_WORDS; j++) begin
			cpu_read_check(base + 16'(j));
		end

		// the DMA block is cached first so stale lines would show up later
		for (int i = 0; i < `DMA_LEN; i++) begin
			cpu_read_check(16'(`DMA_BASE + i));
		end
		run_dma_with_traffic();
		for (int i = 0; i < `DMA_LEN; i++) begin
			cpu_read_check(16'(`DMA_BASE + i));
		end
		check_word(16'(dev_count), 16'(`DMA_LEN), "o_dev_rd pulse count");
		check_word(16'(irq_count), 16'd1, "o_dma_interrupt pulse count");

		$display("errors: %0d data, %0d opcode, %0d timeouts", data_errs, op_errs, timeouts);
		if (data_errs == 0 && op_errs == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- design/mem_subsystem.sv
`timescale 1ns/100ps
`include "mem_defines.svh"

module mem_subsystem (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  mem_pkg::cpu_req_t      i_cpu_req,
	output logic [`WORD_SIZE-1:0]  o_cpu_rdata,
	output logic                   o_cpu_ready,
	output logic                   o_cpu_ack,
	input  logic                   i_ex_interrupt,
	input  logic [`WORD_SIZE-1:0]  i_dev_data,
	output logic                   o_dev_rd,
	output logic                   o_dma_interrupt,
	output logic                   o_bus_grant
);
	import mem_pkg::*;

	mem_req_t               cache_mem_req;
	mem_req_t               dma_mem_req;
	mem_req_t               mem_req;
	line_t                  mem_line;
	logic                   mem_ready;
	logic                   mem_ack;
	logic                   bus_req;
	logic                   bus_grant;
	logic                   cache_busy;
	logic                   snoop_valid;
	logic [`WORD_SIZE-1:0]  snoop_addr;

	// the DMA engine owns the port while granted
	assign mem_req     = bus_grant ? dma_mem_req : cache_mem_req;
	assign o_bus_grant = bus_grant;

	data_cache data_cache_i (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_cpu_req     (i_cpu_req),
		.o_cpu_rdata   (o_cpu_rdata),
		.o_cpu_ready   (o_cpu_ready),
		.o_cpu_ack     (o_cpu_ack),
		.o_mem_req     (cache_mem_req),
		.i_mem_line    (mem_line),
		.i_mem_ready   (mem_ready),
		.i_mem_ack     (mem_ack),
		.i_bus_grant   (bus_grant),
		.o_busy        (cache_busy),
		.i_snoop_valid (snoop_valid),
		.i_snoop_addr  (snoop_addr)
	);

	bus_arbiter bus_arbiter_i (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_bus_req    (bus_req),
		.i_cache_busy (cache_busy),
		.o_bus_grant  (bus_grant)
	);

	dma_engine dma_engine_i (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_start       (i_ex_interrupt),
		.i_dev_data    (i_dev_data),
		.o_dev_rd      (o_dev_rd),
		.o_bus_req     (bus_req),
		.i_bus_grant   (bus_grant),
		.o_mem_req     (dma_mem_req),
		.i_mem_ack     (mem_ack),
		.o_snoop_valid (snoop_valid),
		.o_snoop_addr  (snoop_addr),
		.o_done        (o_dma_interrupt)
	);

	main_memory main_memory_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_req   (mem_req),
		.o_line  (mem_line),
		.o_ready (mem_ready),
		.o_ack   (mem_ack)
	);

endmodule

//--- design/main_memory.sv
`timescale 1ns/100ps
`include "mem_defines.svh"

module main_memory (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  mem_pkg::mem_req_t  i_req,
	output mem_pkg::line_t     o_line,
	output logic               o_ready,
	output logic               o_ack
);
	import mem_pkg::*;

	localparam int AW       = $clog2(`MEM_DEPTH);
	localparam int OFF_W    = $clog2(`LINE_WORDS);
	localparam int CNT_W    = $clog2(`MEM_LAT);
	localparam int LAT_LAST = `MEM_LAT - 1;

	logic [`WORD_SIZE-1:0]  mem [`MEM_DEPTH];
	logic                   busy;
	logic [CNT_W-1:0]       lat_cnt;
	logic                   accept;
	logic                   finish;
	logic [AW-1:0]          word_addr;
	logic [AW-OFF_W-1:0]    line_addr;

	// a request still held during its own pulse is not a new one
	assign accept    = (i_req.op != OP_NONE) && !busy && !o_ready && !o_ack;
	assign finish    = busy && (lat_cnt == CNT_W'(LAT_LAST));
	assign word_addr = i_req.addr[AW-1:0];
	assign line_addr = i_req.addr[AW-1:OFF_W];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy    <= 1'b0;
			lat_cnt <= '0;
			o_ready <= 1'b0;
			o_ack   <= 1'b0;
			for (int i = 0; i < `MEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else begin
			o_ready <= finish && (i_req.op == OP_READ);
			o_ack   <= finish && (i_req.op == OP_WRITE);
			if (accept) begin
				busy    <= 1'b1;
				lat_cnt <= CNT_W'(1);
			end else if (finish) begin
				busy <= 1'b0;
			end else if (busy) begin
				lat_cnt <= lat_cnt + 1'b1;
			end
			if (finish && (i_req.op == OP_WRITE)) begin
				mem[word_addr] <= i_req.wdata;
			end
		end
	end

	// the whole aligned line around the address
	always_ff @(posedge i_clk) begin
		if (finish && (i_req.op == OP_READ)) begin
			for (int i = 0; i < `LINE_WORDS; i++) begin
				o_line[i] <= mem[{line_addr, OFF_W'(i)}];
			end
		end
	end

	a_req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(busy || o_ready || o_ack) |-> $stable(i_req));

endmodule

//--- design/dma_engine.sv
`timescale 1ns/100ps
`include "mem_defines.svh"

module dma_engine (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_start,
	input  logic [`WORD_SIZE-1:0]  i_dev_data,
	output logic                   o_dev_rd,
	output logic                   o_bus_req,
	input  logic                   i_bus_grant,
	output mem_pkg::mem_req_t      o_mem_req,
	input  logic                   i_mem_ack,
	output logic                   o_snoop_valid,
	output logic [`WORD_SIZE-1:0]  o_snoop_addr,
	output logic                   o_done
);
	import mem_pkg::*;

	dma_state_e             state;
	dma_state_e             next_state;
	logic [`WORD_SIZE-1:0]  dev_word;
	logic [`WORD_SIZE-1:0]  cnt_addr;
	logic                   cnt_last;
	logic                   load;
	logic                   write_ack;

	assign load = (state == DMA_IDLE) && i_start;
	// an ack while granted can only answer this engine
	assign write_ack = (state == DMA_WRITE) && i_bus_grant && i_mem_ack;

	dma_counter dma_counter_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_load  (load),
		.i_step  (write_ack),
		.o_addr  (cnt_addr),
		.o_last  (cnt_last)
	);

	always_comb begin
		next_state = state;
		case (state)
			DMA_IDLE: begin
				if (i_start) begin
					next_state = DMA_FETCH;
				end
			end
			DMA_FETCH: begin
				next_state = DMA_WRITE;
			end
			DMA_WRITE: begin
				if (write_ack) begin
					next_state = cnt_last ? DMA_DONE : DMA_FETCH;
				end
			end
			default: begin
				next_state = DMA_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= DMA_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// device word is taken on the edge that ends the read pulse
	always_ff @(posedge i_clk) begin
		if (state == DMA_FETCH) begin
			dev_word <= i_dev_data;
		end
	end

	assign o_dev_rd  = (state == DMA_FETCH);
	assign o_bus_req = (state == DMA_FETCH) || (state == DMA_WRITE);
	assign o_done    = (state == DMA_DONE);

	assign o_mem_req = '{
		op:    ((state == DMA_WRITE) && i_bus_grant) ? OP_WRITE : OP_NONE,
		addr:  cnt_addr,
		wdata: dev_word
	};

	assign o_snoop_valid = write_ack;
	assign o_snoop_addr  = cnt_addr;

endmodule

//--- design/dma_counter.sv
`timescale 1ns/100ps
`include "mem_defines.svh"

module dma_counter (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_load,
	input  logic                   i_step,
	output logic [`WORD_SIZE-1:0]  o_addr,
	output logic                   o_last
);

	localparam int CNT_W = $clog2(`DMA_LEN + 1);

	logic [`WORD_SIZE-1:0]  addr;
	logic [CNT_W-1:0]       remain;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			addr   <= '0;
			remain <= '0;
		end else if (i_load) begin
			addr   <= `DMA_BASE;
			remain <= CNT_W'(`DMA_LEN);
		end else if (i_step) begin
			addr   <= addr + 1'b1;
			remain <= remain - 1'b1;
		end
	end

	assign o_addr = addr;
	// one word left, the next ack ends the block
	assign o_last = (remain == CNT_W'(1));

endmodule

//--- design/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
	input  logic  i_clk,
	input  logic  i_rst_n,
	input  logic  i_bus_req,
	input  logic  i_cache_busy,
	output logic  o_bus_grant
);
	import mem_pkg::*;

	arb_state_e  state;
	arb_state_e  next_state;

	always_comb begin
		next_state = state;
		case (state)
			ARB_CPU: begin
				if (i_bus_req) begin
					next_state = ARB_DRAIN;
				end
			end
			ARB_DRAIN: begin
				// let the cache finish its memory access first
				if (!i_bus_req) begin
					next_state = ARB_CPU;
				end else if (!i_cache_busy) begin
					next_state = ARB_DMA;
				end
			end
			ARB_DMA: begin
				if (!i_bus_req) begin
					next_state = ARB_CPU;
				end
			end
			default: begin
				next_state = ARB_CPU;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ARB_CPU;
		end else begin
			state <= next_state;
		end
	end

	// grant drops in the cycle after the request falls
	assign o_bus_grant = (state == ARB_DMA);

	a_grant_cache_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_bus_grant |-> !i_cache_busy);

endmodule

//--- design/data_cache.sv
`timescale 1ns/100ps
`include "mem_defines.svh"

module data_cache (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  mem_pkg::cpu_req_t      i_cpu_req,
	output logic [`WORD_SIZE-1:0]  o_cpu_rdata,
	output logic                   o_cpu_ready,
	output logic                   o_cpu_ack,
	output mem_pkg::mem_req_t      o_mem_req,
	input  mem_pkg::line_t         i_mem_line,
	input  logic                   i_mem_ready,
	input  logic                   i_mem_ack,
	input  logic                   i_bus_grant,
	output logic                   o_busy,
	input  logic                   i_snoop_valid,
	input  logic [`WORD_SIZE-1:0]  i_snoop_addr
);
	import mem_pkg::*;

	localparam int OFF_W = $clog2(`LINE_WORDS);
	localparam int IDX_W = $clog2(`CACHE_LINES);
	localparam int TAG_W = `WORD_SIZE - OFF_W - IDX_W;

	logic [`CACHE_LINES-1:0]  valid;
	logic [TAG_W-1:0]         tags [`CACHE_LINES];
	line_t                    lines [`CACHE_LINES];

	// memory access in flight, the op doubles as the miss/write state
	mem_op_e                  mem_op;
	logic [`WORD_SIZE-1:0]    mem_addr;
	logic [`WORD_SIZE-1:0]    mem_wdata;

	logic                     ready;
	logic [`WORD_SIZE-1:0]    rdata;
	logic                     wr_gap;

	logic [OFF_W-1:0]  cpu_off;
	logic [IDX_W-1:0]  cpu_idx;
	logic [TAG_W-1:0]  cpu_tag;
	logic [OFF_W-1:0]  mem_off;
	logic [IDX_W-1:0]  mem_idx;
	logic [TAG_W-1:0]  mem_tag;
	logic [IDX_W-1:0]  snoop_idx;
	logic [TAG_W-1:0]  snoop_tag;

	logic  cpu_hit;
	logic  cpu_idle;
	logic  start_hit;
	logic  start_mem;
	logic  refill_done;

	assign cpu_off   = i_cpu_req.addr[OFF_W-1:0];
	assign cpu_idx   = i_cpu_req.addr[OFF_W +: IDX_W];
	assign cpu_tag   = i_cpu_req.addr[`WORD_SIZE-1 -: TAG_W];
	assign mem_off   = mem_addr[OFF_W-1:0];
	assign mem_idx   = mem_addr[OFF_W +: IDX_W];
	assign mem_tag   = mem_addr[`WORD_SIZE-1 -: TAG_W];
	assign snoop_idx = i_snoop_addr[OFF_W +: IDX_W];
	assign snoop_tag = i_snoop_addr[`WORD_SIZE-1 -: TAG_W];

	assign cpu_hit  = valid[cpu_idx] && (tags[cpu_idx] == cpu_tag);
	// the cycles of a ready pulse and right after a write ack belong to the old request
	assign cpu_idle = (mem_op == OP_NONE) && !ready && !wr_gap;

	assign start_hit = cpu_idle && (i_cpu_req.op == OP_READ) && cpu_hit;
	// misses and stores need the port, so they wait out a DMA grant
	assign start_mem = cpu_idle && !i_bus_grant &&
		(((i_cpu_req.op == OP_READ) && !cpu_hit) || (i_cpu_req.op == OP_WRITE));

	assign refill_done = i_mem_ready && (mem_op == OP_READ);
	assign o_cpu_ack   = i_mem_ack && (mem_op == OP_WRITE);

	// a starting access already counts, so the arbiter cannot grant under it
	assign o_busy = (mem_op != OP_NONE) || start_mem;

	assign o_mem_req   = '{op: mem_op, addr: mem_addr, wdata: mem_wdata};
	assign o_cpu_ready = ready;
	assign o_cpu_rdata = rdata;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid  <= '0;
			mem_op <= OP_NONE;
			ready  <= 1'b0;
			wr_gap <= 1'b0;
		end else begin
			ready  <= start_hit || refill_done;
			wr_gap <= o_cpu_ack;
			if (start_mem) begin
				mem_op <= i_cpu_req.op;
			end else if (refill_done || o_cpu_ack) begin
				mem_op <= OP_NONE;
			end
			if (refill_done) begin
				valid[mem_idx] <= 1'b1;
			end
			// a DMA store makes the cached copy stale
			if (i_snoop_valid && valid[snoop_idx] && (tags[snoop_idx] == snoop_tag)) begin
				valid[snoop_idx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (start_mem) begin
			mem_addr  <= i_cpu_req.addr;
			mem_wdata <= i_cpu_req.wdata;
		end
		if (start_hit) begin
			rdata <= lines[cpu_idx][cpu_off];
		end
		if (refill_done) begin
			tags[mem_idx]  <= mem_tag;
			lines[mem_idx] <= i_mem_line;
			rdata          <= i_mem_line[mem_off];
		end
		// write-through, a hit line takes the new word as well
		if (start_mem && (i_cpu_req.op == OP_WRITE) && cpu_hit) begin
			lines[cpu_idx][cpu_off] <= i_cpu_req.wdata;
		end
	end

	a_ready_ack_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_cpu_ready && o_cpu_ack));

endmodule

//--- design/mem_pkg.sv
`include "mem_defines.svh"

package mem_pkg;

	// memory and CPU opcodes
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_READ  = 2'd1,
		OP_WRITE = 2'd2
	} mem_op_e;

	// request from the CPU side, held until ready or ack
	typedef struct packed {
		mem_op_e                op;
		logic [`WORD_SIZE-1:0]  addr;
		logic [`WORD_SIZE-1:0]  wdata;
	} cpu_req_t;

	// request on the shared memory port
	typedef struct packed {
		mem_op_e                op;
		logic [`WORD_SIZE-1:0]  addr;
		logic [`WORD_SIZE-1:0]  wdata;
	} mem_req_t;

	// one cache line, word 0 in the low bits
	typedef logic [`LINE_WORDS-1:0][`WORD_SIZE-1:0] line_t;

	typedef enum logic [1:0] {
		ARB_CPU,
		ARB_DRAIN,
		ARB_DMA
	} arb_state_e;

	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_FETCH,
		DMA_WRITE,
		DMA_DONE
	} dma_state_e;

endpackage

//--- design/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// data and address word size
`define WORD_SIZE 16

// words per cache line
`define LINE_WORDS 4

// direct-mapped cache size in lines
`define CACHE_LINES 8

// main memory depth in words, higher addresses alias onto the low bits
`define MEM_DEPTH 256

// cycles from the first sight of a request to its ready or ack pulse
`define MEM_LAT 3

// fixed DMA block, first target address and word count
`define DMA_BASE 16'h17
`define DMA_LEN 12

`endif
